// ==== verilog/tl_pkg.sv ====
package tl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  mask_t;
  typedef logic [2:0]  size_t;
  typedef logic [3:0]  source_t;

  // log2 of bytes per beat; 4-byte data beats
  localparam int unsigned NonBurstSize = 2;
  // Largest message is 16 bytes
  localparam int unsigned MaxSize      = 4;
  localparam int unsigned MaxBurstLen  = 2 ** (MaxSize - NonBurstSize);

  // Beats still to come after the current one
  typedef logic [$clog2(MaxBurstLen)-1:0] beat_cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes and channel payloads
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    PutPartialData = 3'd1,
    Get            = 3'd4
  } tl_a_op_e;

  // Bit 0 set means the response carries data
  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } tl_d_op_e;

  typedef struct packed {
    tl_a_op_e opcode;
    size_t    size;
    source_t  source;
    addr_t    address;
    mask_t    mask;
    data_t    data;
  } tl_a_t;

  typedef struct packed {
    tl_d_op_e opcode;
    size_t    size;
    source_t  source;
    logic     denied;
    data_t    data;
  } tl_d_t;

  // Number of beats minus one for a message of the given size
  function automatic beat_cnt_t burst_len(input size_t size);
    if (size <= NonBurstSize) begin
      return '0;
    end else begin
      return beat_cnt_t'((1 << (size - NonBurstSize)) - 1);
    end
  endfunction

endpackage

// ==== verilog/tl_rr_arbiter.sv ====
`timescale 1ns/1ps

module tl_rr_arbiter #(
  parameter int unsigned NumLinks = 3,
  localparam int unsigned LinkW   = (NumLinks > 1) ? $clog2(NumLinks) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable,
  input  logic [NumLinks-1:0] request,
  output logic [NumLinks-1:0] grant
);

  logic [LinkW-1:0] ptr_q;
  logic [LinkW-1:0] win_idx;
  logic             found;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned idx;
    grant   = '0;
    win_idx = ptr_q;
    found   = 1'b0;
    for (int unsigned off = 0; off < NumLinks; off++) begin
      idx = (ptr_q + off) % NumLinks;
      if (enable && !found && request[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        win_idx    = LinkW'(idx);
      end
    end
  end

  // Winner drops to lowest priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= (win_idx == LinkW'(NumLinks - 1)) ? '0 : win_idx + 1'b1;
    end
  end

  // Last winner and the requesters it was chosen over
  logic [NumLinks-1:0] last_grant_q;
  logic [NumLinks-1:0] passed_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_grant_q <= '0;
      passed_q     <= '0;
    end else if (found) begin
      last_grant_q <= grant;
      passed_q     <= request & ~grant;
    end
  end

  // A passed-over link still waiting wins before the last winner wins again
  a_no_repeat_win: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    found && (grant == last_grant_q) |-> (passed_q & request) == '0
  ) else $error("grant %b repeated while %b waits", grant, passed_q & request);

endmodule

// ==== verilog/tl_req_demux.sv ====
`timescale 1ns/1ps

module tl_req_demux #(
  parameter int unsigned NumLinks  = 3,
  parameter int unsigned NumRanges = 3,
  localparam int unsigned LinkW    = (NumLinks > 1) ? $clog2(NumLinks) : 1,

  // Later ranges take priority over earlier ones
  parameter tl_pkg::addr_t [NumRanges-1:0]    AddrBase = '0,
  parameter tl_pkg::addr_t [NumRanges-1:0]    AddrMask = '0,
  parameter logic [NumRanges-1:0][LinkW-1:0] AddrLink = '0
) (
  input  tl_pkg::tl_a_t                in_a,
  input  logic                         in_valid,
  output logic                         in_ready,

  output tl_pkg::tl_a_t [NumLinks-1:0] out_a,
  output logic [NumLinks-1:0]          out_valid,
  input  logic [NumLinks-1:0]          out_ready
);

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  logic [LinkW-1:0]    link_sel;
  logic [NumLinks-1:0] link_hit;

  // Walk all ranges, the last match sticks; unmapped goes to link 0
  always_comb begin
    link_sel = '0;
    for (int r = 0; r < NumRanges; r++) begin
      if ((in_a.address & ~AddrMask[r]) == AddrBase[r]) begin
        link_sel = AddrLink[r];
      end
    end
  end

  always_comb begin
    link_hit = '0;
    for (int i = 0; i < NumLinks; i++) begin
      link_hit[i] = (link_sel == LinkW'(i));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake steering
  //////////////////////////////////////////////////////////////////////

  // Payload is broadcast, only valid is steered
  assign out_a     = {NumLinks{in_a}};
  assign out_valid = link_hit & {NumLinks{in_valid}};
  assign in_ready  = |(link_hit & out_ready);

  // A request reaches exactly one existing link
  always_comb begin
    assert (!in_valid || $onehot(out_valid))
      else $error("request steered to links %b", out_valid);
  end

endmodule

// ==== verilog/tl_rsp_mux.sv ====
`timescale 1ns/1ps

module tl_rsp_mux #(
  parameter int unsigned NumLinks = 3
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  input  tl_pkg::tl_d_t [NumLinks-1:0] in_d,
  input  logic [NumLinks-1:0]          in_valid,
  output logic [NumLinks-1:0]          in_ready,

  output tl_pkg::tl_d_t                out_d,
  output logic                         out_valid,
  input  logic                         out_ready
);

  import tl_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Arbitration and lock
  //////////////////////////////////////////////////////////////////////

  logic [NumLinks-1:0] arb_grant;
  logic                locked_q;
  logic [NumLinks-1:0] selected_q;
  logic                out_fire;
  logic                out_last;

  tl_rr_arbiter #(
    .NumLinks (NumLinks)
  ) u_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .enable  (!locked_q),
    .request (in_valid),
    .grant   (arb_grant)
  );

  // Stay on one link until the last beat of its message
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      locked_q   <= 1'b0;
      selected_q <= '0;
    end else if (locked_q) begin
      if (out_fire && out_last) begin
        locked_q <= 1'b0;
      end
    end else if (|arb_grant) begin
      locked_q   <= 1'b1;
      selected_q <= arb_grant;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output multiplexing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    out_d     = '0;
    out_valid = 1'b0;
    for (int i = 0; i < NumLinks; i++) begin
      if (selected_q[i]) begin
        out_d     = in_d[i];
        out_valid = locked_q && in_valid[i];
      end
    end
  end

  assign in_ready = selected_q & {NumLinks{locked_q && out_ready}};
  assign out_fire = out_valid && out_ready;

  //////////////////////////////////////////////////////////////////////
  // Message boundary
  //////////////////////////////////////////////////////////////////////

  beat_cnt_t len_q;

  // Loaded on the first data beat, then counts down to the last
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len_q <= '0;
    end else if (out_fire) begin
      if (len_q == '0) begin
        if (out_d.opcode[0]) begin
          len_q <= burst_len(out_d.size);
        end
      end else begin
        len_q <= len_q - 1'b1;
      end
    end
  end

  // Single-beat message, or the final beat of a burst
  assign out_last = (len_q == '0) ? (!out_d.opcode[0] || burst_len(out_d.size) == '0)
                                  : (len_q == beat_cnt_t'(1));

  a_out_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid && !out_ready |=> out_valid && $stable(out_d)
  ) else $error("D payload changed while stalled");

endmodule

// ==== verilog/tl_socket_1n.sv ====
`timescale 1ns/1ps

module tl_socket_1n #(
  parameter int unsigned NumLinks  = 3,
  parameter int unsigned NumRanges = 3,
  localparam int unsigned LinkW    = (NumLinks > 1) ? $clog2(NumLinks) : 1,

  // Routing table; range 2 sits inside range 1 and overrides it
  parameter tl_pkg::addr_t [NumRanges-1:0] AddrBase = {
    32'h1800_0000, 32'h1000_0000, 32'h0000_0000
  },
  parameter tl_pkg::addr_t [NumRanges-1:0] AddrMask = {
    32'h00FF_FFFF, 32'h0FFF_FFFF, 32'h0FFF_FFFF
  },
  parameter logic [NumRanges-1:0][LinkW-1:0] AddrLink = {
    LinkW'(0), LinkW'(2), LinkW'(1)
  }
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Host side
  input  tl_pkg::tl_a_t                host_a,
  input  logic                         host_a_valid,
  output logic                         host_a_ready,
  output tl_pkg::tl_d_t                host_d,
  output logic                         host_d_valid,
  input  logic                         host_d_ready,

  // Device links
  output tl_pkg::tl_a_t [NumLinks-1:0] dev_a,
  output logic [NumLinks-1:0]          dev_a_valid,
  input  logic [NumLinks-1:0]          dev_a_ready,
  input  tl_pkg::tl_d_t [NumLinks-1:0] dev_d,
  input  logic [NumLinks-1:0]          dev_d_valid,
  output logic [NumLinks-1:0]          dev_d_ready
);

  //////////////////////////////////////////////////////////////////////
  // A channel, host to one device
  //////////////////////////////////////////////////////////////////////

  tl_req_demux #(
    .NumLinks  (NumLinks),
    .NumRanges (NumRanges),
    .AddrBase  (AddrBase),
    .AddrMask  (AddrMask),
    .AddrLink  (AddrLink)
  ) u_req_demux (
    .in_a      (host_a),
    .in_valid  (host_a_valid),
    .in_ready  (host_a_ready),
    .out_a     (dev_a),
    .out_valid (dev_a_valid),
    .out_ready (dev_a_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // D channel, devices merged to host
  //////////////////////////////////////////////////////////////////////

  tl_rsp_mux #(
    .NumLinks (NumLinks)
  ) u_rsp_mux (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_d      (dev_d),
    .in_valid  (dev_d_valid),
    .in_ready  (dev_d_ready),
    .out_d     (host_d),
    .out_valid (host_d_valid),
    .out_ready (host_d_ready)
  );

endmodule

// ==== dv/tb_tl_socket_1n.sv ====
`timescale 1ns/1ps

module tb_tl_socket_1n;

  import tl_pkg::*;

  localparam int NumLinks      = 3;
  localparam int NumReqs       = 200;
  localparam int MaxBeats      = 4;
  localparam int MaxDelay      = 20;
  localparam int TimeoutCycles = NumReqs * (MaxBeats + MaxDelay) * 2;

  logic                         clk_i;
  logic                         rst_ni;
  tl_a_t                        host_a;
  logic                         host_a_valid;
  logic                         host_a_ready;
  tl_d_t                        host_d;
  logic                         host_d_valid;
  logic                         host_d_ready;
  tl_a_t [NumLinks-1:0]         dev_a;
  logic [NumLinks-1:0]          dev_a_valid;
  logic [NumLinks-1:0]          dev_a_ready;
  tl_d_t [NumLinks-1:0]         dev_d;
  logic [NumLinks-1:0]          dev_d_valid;
  logic [NumLinks-1:0]          dev_d_ready;

  integer      seed;
  logic        go;
  int          err_val;
  int          err_other;
  int          n_checks;
  int          sent;
  int          rsp_cnt;
  // Per source tag, host view
  logic [15:0] pend_valid;
  tl_a_t       pend_req [16];
  int          beat_no [16];
  logic        burst_active;
  source_t     burst_src;
  int          skip_cnt [NumLinks];
  // Device models
  tl_a_t       dev_q [NumLinks][$];
  int          d_beat [NumLinks];
  int          d_wait [NumLinks];

  tl_socket_1n #(
    .NumLinks  (NumLinks),
    .NumRanges (3)
  ) uut (
    .clk_i, .rst_ni, .host_a, .host_a_valid, .host_a_ready, .host_d, .host_d_valid,
    .host_d_ready, .dev_a, .dev_a_valid, .dev_a_ready, .dev_d, .dev_d_valid, .dev_d_ready
  );

  always #2 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int rand_range(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic rand_bit();
    return rand_range(2) == 1;
  endfunction

  // Last matching range wins, unmapped goes to link 0
  function automatic int ref_link(input addr_t addr);
    int link;
    link = 0;
    if ((addr & ~32'h0FFF_FFFF) == 32'h0000_0000)
      link = 1;
    if ((addr & ~32'h0FFF_FFFF) == 32'h1000_0000)
      link = 2;
    if ((addr & ~32'h00FF_FFFF) == 32'h1800_0000)
      link = 0;
    return link;
  endfunction

  function automatic int ref_beats(input tl_a_t req);
    if (req.opcode == Get && req.size > 3'd2)
      return 32'd1 << (req.size - 3'd2);
    return 1;
  endfunction

  function automatic data_t ref_data(input int link, input addr_t addr, input int beat);
    return (addr + 32'(beat * 4)) ^ {8'(link + 1), 24'hC35A96};
  endfunction

  function automatic tl_d_t make_rsp(input int link, input tl_a_t req, input int beat);
    tl_d_t d;
    d.opcode = (req.opcode == Get) ? AccessAckData : AccessAck;
    d.size   = req.size;
    d.source = req.source;
    d.denied = 1'b0;
    d.data   = (req.opcode == Get) ? ref_data(link, req.address, beat) : '0;
    return d;
  endfunction

  function automatic tl_a_t new_request(input source_t src);
    tl_a_t a;
    a.opcode  = rand_bit() ? Get : (rand_bit() ? PutFullData : PutPartialData);
    a.size    = size_t'(rand_range(5));
    a.source  = src;
    a.address = $random(seed);
    // Bias toward the mapped windows and the overlap
    case (rand_range(4))
      0: a.address[31:28] = 4'h0;
      1: a.address[31:28] = 4'h1;
      2: a.address[31:24] = 8'h18;
      default: ;
    endcase
    a.mask = 4'hF;
    a.data = $random(seed);
    return a;
  endfunction

  task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
    n_checks++;
    if (exp !== act) begin
      err_val++;
      $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  task automatic report(input string what);
    err_other++;
    $display("ERROR %0t %s", $time, what);
  endtask

  task automatic finish_run();
    $display("Done: %0d checks, %0d value errors, %0d other errors",
             n_checks, err_val, err_other);
    if (err_val + err_other == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host driver and device models
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    source_t src;
    if (go) begin
      host_d_ready <= rand_bit();
      if (host_a_valid && host_a_ready) begin
        pend_valid[host_a.source] <= 1'b1;
        pend_req[host_a.source]   <= host_a;
        sent = sent + 1;
        host_a_valid <= 1'b0;
      end
      // One outstanding request per source tag
      if ((!host_a_valid || host_a_ready) && sent < NumReqs) begin
        src = source_t'(rand_range(16));
        if (!pend_valid[src] && !(host_a_valid && host_a.source == src)) begin
          host_a       <= new_request(src);
          host_a_valid <= 1'b1;
        end
      end
      for (int i = 0; i < NumLinks; i++) begin
        dev_a_ready[i] <= rand_bit();
        if (dev_a_valid[i] && dev_a_ready[i]) begin
          dev_q[i].push_back(dev_a[i]);
        end
        if (dev_d_valid[i] && dev_d_ready[i]) begin
          if (d_beat[i] + 1 == ref_beats(dev_q[i][0])) begin
            void'(dev_q[i].pop_front());
            d_beat[i] = 0;
            d_wait[i] = rand_range(MaxDelay);
            dev_d_valid[i] <= 1'b0;
          end else begin
            d_beat[i] = d_beat[i] + 1;
            dev_d[i] <= make_rsp(i, dev_q[i][0], d_beat[i]);
          end
        end else if (!dev_d_valid[i]) begin
          if (d_wait[i] > 0) begin
            d_wait[i] = d_wait[i] - 1;
          end else if (dev_q[i].size() > 0) begin
            dev_d_valid[i] <= 1'b1;
            dev_d[i]       <= make_rsp(i, dev_q[i][0], 0);
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    logic [NumLinks-1:0] exp_valid;
    source_t             src;
    tl_d_op_e            exp_op;
    int                  link;
    if (go) begin
      link = ref_link(host_a.address);
      for (int i = 0; i < NumLinks; i++) begin
        exp_valid[i] = host_a_valid && (link == i);
        if (dev_a_valid[i]) begin
          check("dev_a", 128'(host_a), 128'(dev_a[i]));
        end
        if (host_a_valid && link == i) begin
          check("host_a_ready", 128'(dev_a_ready[i]), 128'(host_a_ready));
        end
      end
      check("dev_a_valid", 128'(exp_valid), 128'(dev_a_valid));

      if (host_d_valid && host_d_ready) begin
        src = host_d.source;
        if (!pend_valid[src]) begin
          report($sformatf("response beat for source %0d has no pending request", src));
        end else begin
          link   = ref_link(pend_req[src].address);
          exp_op = (pend_req[src].opcode == Get) ? AccessAckData : AccessAck;
          if (burst_active && burst_src != src) begin
            report($sformatf("beat of source %0d cut into burst of source %0d",
                             src, burst_src));
          end
          check("host_d.opcode", 128'(exp_op), 128'(host_d.opcode));
          check("host_d.size", 128'(pend_req[src].size), 128'(host_d.size));
          check("host_d.denied", 128'(1'b0), 128'(host_d.denied));
          if (exp_op == AccessAckData) begin
            check("host_d.data", 128'(ref_data(link, pend_req[src].address, beat_no[src])),
                  128'(host_d.data));
          end
          beat_no[src] = beat_no[src] + 1;
          if (beat_no[src] == ref_beats(pend_req[src])) begin
            beat_no[src]      = 0;
            pend_valid[src]  <= 1'b0;
            rsp_cnt           = rsp_cnt + 1;
            burst_active      = 1'b0;
            // Round robin: a waiting link sees at most one message per other link
            for (int j = 0; j < NumLinks; j++) begin
              if (j == link || !dev_d_valid[j]) begin
                skip_cnt[j] = 0;
              end else begin
                skip_cnt[j] = skip_cnt[j] + 1;
                if (skip_cnt[j] >= NumLinks) begin
                  report($sformatf("link %0d passed over %0d times", j, skip_cnt[j]));
                end
              end
            end
          end else begin
            burst_active = 1'b1;
            burst_src    = src;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequence and timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed = 32'h73b2f37a;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    go = 1'b0;
    host_a = '0;
    host_a_valid = 1'b0;
    host_d_ready = 1'b0;
    dev_a_ready = '0;
    dev_d = '0;
    dev_d_valid = '0;
    pend_valid = '0;
    burst_active = 1'b0;
    burst_src = '0;
    err_val = 0;
    err_other = 0;
    n_checks = 0;
    sent = 0;
    rsp_cnt = 0;
    for (int s = 0; s < 16; s++) begin
      beat_no[s] = 0;
    end
    for (int i = 0; i < NumLinks; i++) begin
      d_beat[i] = 0;
      d_wait[i] = 0;
      skip_cnt[i] = 0;
    end
    // Outputs idle through reset and until stimulus starts
    for (int c = 0; c < 5; c++) begin
      @(posedge clk_i);
      if (c == 1) begin
        rst_ni <= 1'b1;
      end
      check("host_d_valid", 128'(1'b0), 128'(host_d_valid));
      check("dev_a_valid", 128'(0), 128'(dev_a_valid));
      check("dev_d_ready", 128'(0), 128'(dev_d_ready));
    end
    go <= 1'b1;
    wait (rsp_cnt == NumReqs);
    repeat (20) @(posedge clk_i);
    // Requests a device accepted but never answered were duplicated on A
    for (int i = 0; i < NumLinks; i++) begin
      if (dev_q[i].size() != 0) begin
        report($sformatf("link %0d still holds %0d unanswered requests",
                         i, dev_q[i].size()));
      end
    end
    finish_run();
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    report($sformatf("timeout after %0d cycles, %0d of %0d responses complete",
                     cycles, rsp_cnt, NumReqs));
    finish_run();
  end

endmodule

// ==== files.f ====
verilog/tl_pkg.sv
verilog/tl_rr_arbiter.sv
verilog/tl_req_demux.sv
verilog/tl_rsp_mux.sv
verilog/tl_socket_1n.sv
dv/tb_tl_socket_1n.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_tl_socket_1n
FILELIST ?= files.f
BUILD    ?= obj_dir
LOG      ?= sim.log
FAIL_MSG := Something failed
PASS_MSG := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "result: FAIL, no verdict"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf $(BUILD) $(LOG)
